/* files.f */
+incdir+hw
hw/rv_decode_pkg.sv
hw/decode_stage_if.sv
hw/op_decode.sv
hw/operand_extract.sv
hw/rv_decoder_top.sv
dv/decode_checker.sv
dv/tb_rv_decoder.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/10ps -j 0
TOP      := tb_rv_decoder
FILELIST := files.f

OBJDIR   := obj_dir
LOG      := sim.log
PASS     := NO ERRORS
SOURCES  := $(shell grep -v '^+' $(FILELIST)) hw/decoder_config.svh

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)

/* dv/tb_rv_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decoder_config.svh"

module tb_rv_decoder;

    logic                   clk;
    logic                   rst;
    logic [`XLEN-1:0]       instruction;
    rv_decode_pkg::op_e     op;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       imm;
    logic                   has_imm;
    wire  [31:0]            mismatches;
    wire  [31:0]            checked;
    int                     timeouts = 0;
    logic [31:0]            lfsr = 32'd86960;

    rv_decoder_top DUT (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .op          (op),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .has_imm     (has_imm)
    );

    decode_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .op          (op),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .has_imm     (has_imm),
        .errors      (mismatches),
        .checks      (checked)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [6:0] pick_opcode(input logic [3:0] sel);
        case (sel)
            4'd0:         return rv_decode_pkg::OPC_LUI;
            4'd1:         return rv_decode_pkg::OPC_AUIPC;
            4'd2:         return rv_decode_pkg::OPC_JAL;
            4'd3:         return rv_decode_pkg::OPC_JALR;
            4'd4, 4'd5:   return rv_decode_pkg::OPC_BRANCH;
            4'd6, 4'd7:   return rv_decode_pkg::OPC_LOAD;
            4'd8, 4'd9:   return rv_decode_pkg::OPC_STORE;
            4'd10, 4'd11,
            4'd12:        return rv_decode_pkg::OPC_OPIMM;
            default:      return rv_decode_pkg::OPC_OP;
        endcase
    endfunction

    task automatic build_word(output logic [31:0] w);
        logic [31:0] kind;
        logic [31:0] sel;
        logic [31:0] rnd;
        take_bits(2, kind);
        case (kind[1:0])
            2'b00, 2'b01: begin  // legal opcode with random fields
                take_bits(4, sel);
                take_bits(25, rnd);
                w = {rnd[24:0], pick_opcode(sel[3:0])};
            end
            2'b10:   take_bits(32, w);
            default: w = '0;
        endcase
    endtask

    initial begin
        logic [31:0] word;
        int          waited;
        int          idle;
        rst         = 1'b0;
        instruction = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;

        for (int i = 0; i < 3000; i++) begin
            @(posedge clk);
            build_word(word);
            instruction <= word;
        end
        @(posedge clk);
        instruction <= '0;

        // drain until three quiet cycles in a row
        waited = 0;
        idle   = 0;
        while (idle < 3 && waited < 20) begin
            @(negedge clk);
            waited++;
            idle = (op == rv_decode_pkg::OP_NONE) ? idle + 1 : 0;
        end
        if (idle < 3) begin
            $display("timeout: pipeline did not drain within 20 cycles");
            timeouts++;
        end
        @(posedge clk);  // last negedge compare has settled

        $display("checked %0d words, %0d mismatches, %0d timeouts",
                 checked, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0 && checked > 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/decode_checker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decoder_config.svh"

module decode_checker (
    input  wire                    clk,
    input  wire                    rst,
    input  wire [`XLEN-1:0]        instruction,
    input  wire [`OP_W-1:0]        op,
    input  wire [`REG_ADDR_W-1:0]  rs1,
    input  wire [`REG_ADDR_W-1:0]  rs2,
    input  wire [`REG_ADDR_W-1:0]  rd,
    input  wire [`XLEN-1:0]        imm,
    input  wire                    has_imm,
    output wire [31:0]             errors,
    output wire [31:0]             checks
);

    int err_cnt = 0;
    int chk_cnt = 0;
    int seen    = 0;

    logic [`XLEN-1:0] word_q1;  // captured at the coming edge
    logic [`XLEN-1:0] word_q2;
    logic             rst_q1;
    logic             rst_q2;

    rv_decode_pkg::op_e     e_op;
    logic [`REG_ADDR_W-1:0] e_rs1;
    logic [`REG_ADDR_W-1:0] e_rs2;
    logic [`REG_ADDR_W-1:0] e_rd;
    logic [`XLEN-1:0]       e_imm;
    logic                   e_has_imm;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    // reference model from the rv32i encoding tables
    task automatic predict(input logic [31:0] w);
        logic [2:0]          f3;
        rv_decode_pkg::fmt_e fmt;
        f3   = w[14:12];
        e_op = rv_decode_pkg::OP_NONE;
        fmt  = rv_decode_pkg::FMT_NONE;
        if (w != '0 && w[1:0] == 2'b11) begin
            case (w[6:0])
                rv_decode_pkg::OPC_LUI: begin
                    e_op = rv_decode_pkg::OP_LUI;
                    fmt  = rv_decode_pkg::FMT_U;
                end
                rv_decode_pkg::OPC_AUIPC: begin
                    e_op = rv_decode_pkg::OP_AUIPC;
                    fmt  = rv_decode_pkg::FMT_U;
                end
                rv_decode_pkg::OPC_JAL: begin
                    e_op = rv_decode_pkg::OP_JAL;
                    fmt  = rv_decode_pkg::FMT_J;
                end
                rv_decode_pkg::OPC_JALR: begin
                    e_op = rv_decode_pkg::OP_JALR;
                    fmt  = rv_decode_pkg::FMT_I;
                end
                rv_decode_pkg::OPC_BRANCH: begin
                    fmt = rv_decode_pkg::FMT_B;
                    case (f3)
                        3'd0:    e_op = rv_decode_pkg::OP_BEQ;
                        3'd1:    e_op = rv_decode_pkg::OP_BNE;
                        3'd4:    e_op = rv_decode_pkg::OP_BLT;
                        3'd5:    e_op = rv_decode_pkg::OP_BGE;
                        3'd6:    e_op = rv_decode_pkg::OP_BLTU;
                        3'd7:    e_op = rv_decode_pkg::OP_BGEU;
                        default: e_op = rv_decode_pkg::OP_NONE;
                    endcase
                end
                rv_decode_pkg::OPC_LOAD: begin
                    fmt = rv_decode_pkg::FMT_I;
                    case (f3)
                        3'd0:    e_op = rv_decode_pkg::OP_LB;
                        3'd1:    e_op = rv_decode_pkg::OP_LH;
                        3'd2:    e_op = rv_decode_pkg::OP_LW;
                        3'd4:    e_op = rv_decode_pkg::OP_LBU;
                        3'd5:    e_op = rv_decode_pkg::OP_LHU;
                        default: e_op = rv_decode_pkg::OP_NONE;
                    endcase
                end
                rv_decode_pkg::OPC_STORE: begin
                    fmt = rv_decode_pkg::FMT_S;
                    case (f3)
                        3'd0:    e_op = rv_decode_pkg::OP_SB;
                        3'd1:    e_op = rv_decode_pkg::OP_SH;
                        3'd2:    e_op = rv_decode_pkg::OP_SW;
                        default: e_op = rv_decode_pkg::OP_NONE;
                    endcase
                end
                rv_decode_pkg::OPC_OPIMM, rv_decode_pkg::OPC_OP: begin
                    case (f3)
                        3'd0: begin
                            if (w[30] && w[6:0] == rv_decode_pkg::OPC_OP) begin
                                e_op = rv_decode_pkg::OP_SUB;
                            end else begin
                                e_op = rv_decode_pkg::OP_ADD;
                            end
                        end
                        3'd1:    e_op = rv_decode_pkg::OP_SLL;
                        3'd2:    e_op = rv_decode_pkg::OP_SLT;
                        3'd3:    e_op = rv_decode_pkg::OP_SLTU;
                        3'd4:    e_op = rv_decode_pkg::OP_XOR;
                        3'd5:    e_op = w[30] ? rv_decode_pkg::OP_SRA : rv_decode_pkg::OP_SRL;
                        3'd6:    e_op = rv_decode_pkg::OP_OR;
                        default: e_op = rv_decode_pkg::OP_AND;
                    endcase
                    if (w[6:0] == rv_decode_pkg::OPC_OP) begin
                        fmt = rv_decode_pkg::FMT_R;
                    end else if (f3 == 3'd1 || f3 == 3'd5) begin
                        fmt = rv_decode_pkg::FMT_SHIFT;
                    end else begin
                        fmt = rv_decode_pkg::FMT_I;
                    end
                end
                default: e_op = rv_decode_pkg::OP_NONE;
            endcase
        end
        if (e_op == rv_decode_pkg::OP_NONE) begin
            fmt = rv_decode_pkg::FMT_NONE;
        end

        e_rd      = (fmt == rv_decode_pkg::FMT_S || fmt == rv_decode_pkg::FMT_B) ? '0 : w[11:7];
        e_rs1     = (fmt == rv_decode_pkg::FMT_U || fmt == rv_decode_pkg::FMT_J) ? '0 : w[19:15];
        e_rs2     = (fmt == rv_decode_pkg::FMT_R || fmt == rv_decode_pkg::FMT_S ||
                     fmt == rv_decode_pkg::FMT_B) ? w[24:20] : '0;
        e_has_imm = (fmt != rv_decode_pkg::FMT_R && fmt != rv_decode_pkg::FMT_NONE);
        case (fmt)
            rv_decode_pkg::FMT_R:     e_imm = 32'hffff_ffff;
            rv_decode_pkg::FMT_I:     e_imm = {{20{w[31]}}, w[31:20]};
            rv_decode_pkg::FMT_SHIFT: e_imm = {27'b0, w[24:20]};
            rv_decode_pkg::FMT_S:     e_imm = {{20{w[31]}}, w[31:25], w[11:7]};
            rv_decode_pkg::FMT_B:     e_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            rv_decode_pkg::FMT_U:     e_imm = {w[31:12], 12'b0};
            rv_decode_pkg::FMT_J:     e_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: begin
                e_imm = '0;
                e_rd  = '0;
                e_rs1 = '0;
            end
        endcase
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    // outputs at negedge n belong to the word captured at edge n-1
    always @(negedge clk) begin
        if (seen >= 2) begin
            if (rst_q1 && rst_q2) begin
                predict(word_q2);
            end else begin
                predict('0);  // reset looks like a bubble
            end
            compare("op", 32'(e_op), 32'(op));
            compare("rs1", 32'(e_rs1), 32'(rs1));
            compare("rs2", 32'(e_rs2), 32'(rs2));
            compare("rd", 32'(e_rd), 32'(rd));
            compare("imm", e_imm, imm);
            compare("has_imm", 32'(e_has_imm), 32'(has_imm));
            chk_cnt++;
        end
        word_q2 = word_q1;
        rst_q2  = rst_q1;
        word_q1 = instruction;
        rst_q1  = rst;
        if (seen < 2) begin
            seen++;
        end
    end

endmodule

`default_nettype wire

/* hw/rv_decoder_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decoder_config.svh"

// two-stage rv32i decode, outputs follow the input word by two clocks
module rv_decoder_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [`XLEN-1:0]         instruction,
    output rv_decode_pkg::op_e      op,
    output logic [`REG_ADDR_W-1:0]  rs1,
    output logic [`REG_ADDR_W-1:0]  rs2,
    output logic [`REG_ADDR_W-1:0]  rd,
    output logic [`XLEN-1:0]        imm,
    output logic                    has_imm
);

    decode_stage_if stage_bus ();

    // stage 1, opcode classification
    op_decode u_op_decode (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .stage       (stage_bus.producer)
    );

    // stage 2, register fields and immediate
    operand_extract u_operand_extract (
        .clk     (clk),
        .rst     (rst),
        .stage   (stage_bus.consumer),
        .op      (op),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .imm     (imm),
        .has_imm (has_imm)
    );

endmodule

`default_nettype wire

/* hw/operand_extract.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decoder_config.svh"

module operand_extract (
    input  wire                     clk,
    input  wire                     rst,
    decode_stage_if.consumer        stage,
    output rv_decode_pkg::op_e      op,
    output logic [`REG_ADDR_W-1:0]  rs1,
    output logic [`REG_ADDR_W-1:0]  rs2,
    output logic [`REG_ADDR_W-1:0]  rd,
    output logic [`XLEN-1:0]        imm,
    output logic                    has_imm
);

    logic [`XLEN-1:7]       ib;   // instruction bits 31..7
    logic                   sgn;
    logic [`REG_ADDR_W-1:0] rd_sel;
    logic [`REG_ADDR_W-1:0] rs1_sel;
    logic [`REG_ADDR_W-1:0] rs2_sel;
    logic [`XLEN-1:0]       imm_sel;
    logic                   has_imm_sel;

    assign ib  = stage.imm_bits;
    assign sgn = ib[`XLEN-1];

    always_comb begin
        rd_sel      = stage.rd;
        rs1_sel     = stage.rs1;
        rs2_sel     = '0;        // only R, S and B read rs2
        imm_sel     = '0;
        has_imm_sel = 1'b1;
        case (stage.fmt)
            rv_decode_pkg::FMT_R: begin
                rs2_sel     = stage.rs2;
                imm_sel     = '1;
                has_imm_sel = 1'b0;
            end
            rv_decode_pkg::FMT_I: begin
                imm_sel = {{(`XLEN-12){sgn}}, ib[31:20]};
            end
            rv_decode_pkg::FMT_SHIFT: begin
                // srai too, bit 30 already went into the op
                imm_sel = {{(`XLEN-5){1'b0}}, ib[24:20]};
            end
            rv_decode_pkg::FMT_S: begin
                rd_sel  = '0;
                rs2_sel = stage.rs2;
                imm_sel = {{(`XLEN-12){sgn}}, ib[31:25], ib[11:7]};
            end
            rv_decode_pkg::FMT_B: begin
                rd_sel  = '0;
                rs2_sel = stage.rs2;
                imm_sel = {{(`XLEN-12){sgn}}, ib[7], ib[30:25], ib[11:8], 1'b0};
            end
            rv_decode_pkg::FMT_U: begin
                rs1_sel = '0;
                imm_sel = {ib[31:12], 12'b0};
            end
            rv_decode_pkg::FMT_J: begin
                rs1_sel = '0;
                imm_sel = {{(`XLEN-20){sgn}}, ib[19:12], ib[20], ib[30:21], 1'b0};
            end
            default: begin
                // bubble, nothing but op survives
                rd_sel      = '0;
                rs1_sel     = '0;
                has_imm_sel = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            op      <= rv_decode_pkg::OP_NONE;
            rs1     <= '0;
            rs2     <= '0;
            rd      <= '0;
            imm     <= '0;
            has_imm <= 1'b0;
        end else begin
            op      <= stage.op;
            rs1     <= rs1_sel;
            rs2     <= rs2_sel;
            rd      <= rd_sel;
            imm     <= imm_sel;
            has_imm <= has_imm_sel;
        end
    end

endmodule

`default_nettype wire

/* hw/op_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decoder_config.svh"

module op_decode (
    input  wire               clk,
    input  wire               rst,
    input  wire [`XLEN-1:0]   instruction,
    decode_stage_if.producer  stage
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                alt;     // bit 30, picks sub / sra
    logic                bubble;
    rv_decode_pkg::op_e  op_nxt;
    rv_decode_pkg::fmt_e fmt_cls;

    // funct3 map shared by the register and immediate ALU groups
    function automatic rv_decode_pkg::op_e alu_op(
        input logic [2:0] f3,
        input logic       sel30,
        input logic       reg_form
    );
        rv_decode_pkg::op_e res;
        case (f3)
            3'b000: begin
                // no SUBI, bit 30 belongs to the immediate there
                if (reg_form && sel30) begin
                    res = rv_decode_pkg::OP_SUB;
                end else begin
                    res = rv_decode_pkg::OP_ADD;
                end
            end
            3'b001:  res = rv_decode_pkg::OP_SLL;
            3'b010:  res = rv_decode_pkg::OP_SLT;
            3'b011:  res = rv_decode_pkg::OP_SLTU;
            3'b100:  res = rv_decode_pkg::OP_XOR;
            3'b101:  res = sel30 ? rv_decode_pkg::OP_SRA : rv_decode_pkg::OP_SRL;
            3'b110:  res = rv_decode_pkg::OP_OR;
            default: res = rv_decode_pkg::OP_AND;
        endcase
        return res;
    endfunction

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign alt    = instruction[30];

    always_comb begin
        op_nxt  = rv_decode_pkg::OP_NONE;
        fmt_cls = rv_decode_pkg::FMT_NONE;
        // 16-bit words and the all-zero word stay OP_NONE
        if (instruction != '0 && instruction[1:0] == 2'b11) begin
            case (opcode)
                rv_decode_pkg::OPC_LUI: begin
                    op_nxt  = rv_decode_pkg::OP_LUI;
                    fmt_cls = rv_decode_pkg::FMT_U;
                end
                rv_decode_pkg::OPC_AUIPC: begin
                    op_nxt  = rv_decode_pkg::OP_AUIPC;
                    fmt_cls = rv_decode_pkg::FMT_U;
                end
                rv_decode_pkg::OPC_JAL: begin
                    op_nxt  = rv_decode_pkg::OP_JAL;
                    fmt_cls = rv_decode_pkg::FMT_J;
                end
                rv_decode_pkg::OPC_JALR: begin
                    op_nxt  = rv_decode_pkg::OP_JALR;
                    fmt_cls = rv_decode_pkg::FMT_I;
                end
                rv_decode_pkg::OPC_BRANCH: begin
                    fmt_cls = rv_decode_pkg::FMT_B;
                    case (funct3)
                        3'b000:  op_nxt = rv_decode_pkg::OP_BEQ;
                        3'b001:  op_nxt = rv_decode_pkg::OP_BNE;
                        3'b100:  op_nxt = rv_decode_pkg::OP_BLT;
                        3'b101:  op_nxt = rv_decode_pkg::OP_BGE;
                        3'b110:  op_nxt = rv_decode_pkg::OP_BLTU;
                        3'b111:  op_nxt = rv_decode_pkg::OP_BGEU;
                        default: op_nxt = rv_decode_pkg::OP_NONE;  // 010, 011
                    endcase
                end
                rv_decode_pkg::OPC_LOAD: begin
                    fmt_cls = rv_decode_pkg::FMT_I;
                    case (funct3)
                        3'b000:  op_nxt = rv_decode_pkg::OP_LB;
                        3'b001:  op_nxt = rv_decode_pkg::OP_LH;
                        3'b010:  op_nxt = rv_decode_pkg::OP_LW;
                        3'b100:  op_nxt = rv_decode_pkg::OP_LBU;
                        3'b101:  op_nxt = rv_decode_pkg::OP_LHU;
                        default: op_nxt = rv_decode_pkg::OP_NONE;
                    endcase
                end
                rv_decode_pkg::OPC_STORE: begin
                    fmt_cls = rv_decode_pkg::FMT_S;
                    case (funct3)
                        3'b000:  op_nxt = rv_decode_pkg::OP_SB;
                        3'b001:  op_nxt = rv_decode_pkg::OP_SH;
                        3'b010:  op_nxt = rv_decode_pkg::OP_SW;
                        default: op_nxt = rv_decode_pkg::OP_NONE;
                    endcase
                end
                rv_decode_pkg::OPC_OPIMM: begin
                    op_nxt = alu_op(funct3, alt, 1'b0);
                    if (funct3 == 3'b001 || funct3 == 3'b101) begin
                        fmt_cls = rv_decode_pkg::FMT_SHIFT;
                    end else begin
                        fmt_cls = rv_decode_pkg::FMT_I;
                    end
                end
                rv_decode_pkg::OPC_OP: begin
                    op_nxt  = alu_op(funct3, alt, 1'b1);
                    fmt_cls = rv_decode_pkg::FMT_R;
                end
                default: begin
                    op_nxt  = rv_decode_pkg::OP_NONE;
                    fmt_cls = rv_decode_pkg::FMT_NONE;
                end
            endcase
        end
    end

    assign bubble = (op_nxt == rv_decode_pkg::OP_NONE);

    always_ff @(posedge clk) begin
        if (!rst || bubble) begin  // reset and illegal words look alike downstream
            stage.op       <= rv_decode_pkg::OP_NONE;
            stage.fmt      <= rv_decode_pkg::FMT_NONE;
            stage.rd       <= '0;
            stage.rs1      <= '0;
            stage.rs2      <= '0;
            stage.imm_bits <= '0;
        end else begin
            stage.op       <= op_nxt;
            stage.fmt      <= fmt_cls;
            stage.rd       <= instruction[11:7];
            stage.rs1      <= instruction[19:15];
            stage.rs2      <= instruction[24:20];
            stage.imm_bits <= instruction[`XLEN-1:7];
        end
    end

endmodule

`default_nettype wire

/* hw/decode_stage_if.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decoder_config.svh"

interface decode_stage_if;

    rv_decode_pkg::op_e     op;        // OP_NONE marks a bubble
    rv_decode_pkg::fmt_e    fmt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;

    // opcode bits are spent in the first stage, only 31..7 go on
    logic [`XLEN-1:7]       imm_bits;

    modport producer (
        output op, fmt, rd, rs1, rs2, imm_bits
    );

    modport consumer (
        input op, fmt, rd, rs1, rs2, imm_bits
    );

endinterface

`default_nettype wire

/* hw/rv_decode_pkg.sv */
`default_nettype none

`include "decoder_config.svh"

package rv_decode_pkg;

    // internal operation codes
    typedef enum logic [`OP_W-1:0] {
        OP_ADD   = 'd0,
        OP_AND   = 'd1,
        OP_OR    = 'd2,
        OP_SLL   = 'd3,
        OP_SRL   = 'd4,
        OP_SLT   = 'd5,
        OP_SLTU  = 'd6,
        OP_SRA   = 'd7,
        OP_SUB   = 'd8,
        OP_XOR   = 'd9,
        OP_BEQ   = 'd10,
        OP_BGE   = 'd11,
        OP_BNE   = 'd12,
        OP_BGEU  = 'd13,
        OP_LUI   = 'd14,
        OP_AUIPC = 'd15,
        OP_JAL   = 'd16,
        OP_JALR  = 'd17,
        OP_LB    = 'd18,
        OP_LH    = 'd19,
        OP_LW    = 'd20,
        OP_LBU   = 'd21,
        OP_LHU   = 'd22,
        OP_SB    = 'd23,
        OP_SH    = 'd24,
        OP_SW    = 'd25,
        OP_BLT   = 'd26,
        OP_BLTU  = 'd27,
        // 28 stays reserved
        OP_NONE  = 'd31  // bubble or illegal word
    } op_e;

    // immediate layout selected in the second stage
    typedef enum logic [2:0] {
        FMT_R     = 3'd0,
        FMT_I     = 3'd1,
        FMT_SHIFT = 3'd2,  // zero-extended shamt
        FMT_S     = 3'd3,
        FMT_B     = 3'd4,
        FMT_U     = 3'd5,
        FMT_J     = 3'd6,
        FMT_NONE  = 3'd7
    } fmt_e;

    // major opcodes in bits 6..0
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

endpackage

`default_nettype wire

/* hw/decoder_config.svh */
`ifndef DECODER_CONFIG_SVH
`define DECODER_CONFIG_SVH

// instruction word and immediate width
`define XLEN 32

// register file index, x0..x31
`define REG_ADDR_W 5

// internal operation code, leaves room for OP_NONE at all ones
`define OP_W 5

`endif
